/* sa_pkg.sv */
package sa_pkg;

    //////////////////////////////
    // array geometry
    //////////////////////////////
    localparam int sa_rows = 2;
    localparam int sa_cols = 2;

    // one weight byte per row, two pixel bytes per column word
    localparam int row_w = 8;
    localparam int col_w = 16;

    // accumulators wrap at this width
    localparam int acc_w = 20;
    // mode 0 fills lanes 0..1, mode 1 fills all four
    localparam int lanes = 4;
    // one element's lanes side by side
    localparam int pe_w = lanes * acc_w;

    //////////////////////////////
    // tile and drain limits
    //////////////////////////////
    localparam int max_depth = 16;
    localparam int depth_w = 5;
    localparam int flush_cycles = sa_rows + sa_cols + 1;
    localparam int flush_w = $clog2(flush_cycles + 1);

    // consumer slots and the credit count after reset
    localparam int out_credits = 2;
    localparam int cred_w = $clog2(out_credits + 1);

    // one output beat carries every row of one channel
    localparam int chan_w = sa_rows * pe_w;
    localparam int chan_idx_w = (sa_cols > 1) ? $clog2(sa_cols) : 1;

endpackage

/* sa_skew.sv */
`timescale 1ns/1ps

module sa_skew #(
    parameter type payload_t = logic [7:0],
    parameter int n = 2
) (
    input  logic             clk,
    input  logic             cnt_rst,
    input  payload_t [n-1:0] in,
    input  logic             in_vld,
    output payload_t [n-1:0] out,
    output logic [n-1:0]     out_vld
);

    // idle cycles push zeros so nothing stale enters the array
    payload_t [n-1:0] gated;

    always_comb begin
        for (int i = 0; i < n; i++) begin
            gated[i] = in_vld ? in[i] : '0;
        end
    end

    // lane i sits behind i register stages
    for (genvar i = 0; i < n; i++) begin : g_lane
        if (i == 0) begin : g_pass
            assign out[0]     = gated[0];
            assign out_vld[0] = in_vld;
        end else begin : g_dly
            payload_t d_q [i];
            logic     v_q [i];

            always_ff @(posedge clk) begin
                d_q[0] <= gated[i];
                for (int k = 1; k < i; k++) begin
                    d_q[k] <= d_q[k-1];
                end
            end

            // valid walks the same chain as its data
            always_ff @(posedge clk) begin
                if (cnt_rst) begin
                    for (int k = 0; k < i; k++) begin
                        v_q[k] <= 1'b0;
                    end
                end else begin
                    v_q[0] <= in_vld;
                    for (int k = 1; k < i; k++) begin
                        v_q[k] <= v_q[k-1];
                    end
                end
            end

            assign out[i]     = d_q[i-1];
            assign out_vld[i] = v_q[i-1];
        end
    end

endmodule

/* sa_pe.sv */
`timescale 1ns/1ps

module sa_pe (
    input  logic                                        clk,
    input  logic                                        cnt_rst,
    input  logic                                        clear,
    input  logic                                        mode,
    input  logic [sa_pkg::row_w-1:0]                    w_in,
    input  logic                                        w_vld_in,
    input  logic [sa_pkg::col_w-1:0]                    px_in,
    input  logic                                        px_vld_in,
    output logic [sa_pkg::row_w-1:0]                    w_out,
    output logic                                        w_vld_out,
    output logic [sa_pkg::col_w-1:0]                    px_out,
    output logic                                        px_vld_out,
    output logic [sa_pkg::lanes-1:0][sa_pkg::acc_w-1:0] acc
);

    // signed views of the operands
    logic signed [7:0]  w8;
    logic signed [3:0]  nib [2];
    logic signed [7:0]  pb [2];
    // 8x8 and 4x8 products before widening
    logic signed [15:0] m8 [2];
    logic signed [11:0] m4 [4];
    logic [sa_pkg::acc_w-1:0] prod [sa_pkg::lanes];

    //////////////////////////////
    // product lanes
    //////////////////////////////
    always_comb begin
        w8     = w_in;
        nib[0] = w_in[3:0];
        nib[1] = w_in[7:4];
        pb[0]  = px_in[7:0];
        pb[1]  = px_in[15:8];
        for (int p = 0; p < 2; p++) begin
            m8[p] = w8 * pb[p];
        end
        // lane 2w+p pairs nibble w with byte p
        for (int w = 0; w < 2; w++) begin
            for (int p = 0; p < 2; p++) begin
                m4[2*w+p] = nib[w] * pb[p];
            end
        end
        for (int l = 0; l < sa_pkg::lanes; l++) begin
            prod[l] = '0;
        end
        if (mode) begin
            for (int l = 0; l < sa_pkg::lanes; l++) begin
                prod[l] = sa_pkg::acc_w'(m4[l]);
            end
        end else begin
            // lanes 2 and 3 stay zero in 8x8
            prod[0] = sa_pkg::acc_w'(m8[0]);
            prod[1] = sa_pkg::acc_w'(m8[1]);
        end
    end

    // clear wins over a same-cycle step
    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (w_vld_in && px_vld_in) begin
            for (int l = 0; l < sa_pkg::lanes; l++) begin
                acc[l] <= acc[l] + prod[l];
            end
        end
    end

    //////////////////////////////
    // forwarding to neighbors
    //////////////////////////////
    always_ff @(posedge clk) begin
        w_out  <= w_in;
        px_out <= px_in;
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            w_vld_out  <= 1'b0;
            px_vld_out <= 1'b0;
        end else begin
            w_vld_out  <= w_vld_in;
            px_vld_out <= px_vld_in;
        end
    end

endmodule

/* sa_array.sv */
`timescale 1ns/1ps

module sa_array (
    input  logic                                                          clk,
    input  logic                                                          cnt_rst,
    input  logic                                                          clear,
    input  logic                                                          mode,
    input  logic [sa_pkg::sa_rows-1:0][sa_pkg::row_w-1:0]                 w_in,
    input  logic [sa_pkg::sa_rows-1:0]                                    w_vld,
    input  logic [sa_pkg::sa_cols-1:0][sa_pkg::col_w-1:0]                 px_in,
    input  logic [sa_pkg::sa_cols-1:0]                                    px_vld,
    output logic [sa_pkg::sa_rows-1:0][sa_pkg::sa_cols-1:0][sa_pkg::pe_w-1:0] acc_all
);

    // horizontal weight links where entry c feeds element c of the row
    logic [sa_pkg::row_w-1:0] w_bus  [sa_pkg::sa_rows][sa_pkg::sa_cols+1];
    logic                     w_vbus [sa_pkg::sa_rows][sa_pkg::sa_cols+1];
    // vertical pixel links where entry r feeds element r of the column
    logic [sa_pkg::col_w-1:0] px_bus  [sa_pkg::sa_rows+1][sa_pkg::sa_cols];
    logic                     px_vbus [sa_pkg::sa_rows+1][sa_pkg::sa_cols];

    //////////////////////////////
    // array edges
    //////////////////////////////
    for (genvar r = 0; r < sa_pkg::sa_rows; r++) begin : g_west
        assign w_bus[r][0]  = w_in[r];
        assign w_vbus[r][0] = w_vld[r];
    end

    for (genvar c = 0; c < sa_pkg::sa_cols; c++) begin : g_north
        assign px_bus[0][c]  = px_in[c];
        assign px_vbus[0][c] = px_vld[c];
    end

    // element (r, c) passes weights to (r, c+1) and pixels to (r+1, c)
    for (genvar r = 0; r < sa_pkg::sa_rows; r++) begin : g_row
        for (genvar c = 0; c < sa_pkg::sa_cols; c++) begin : g_col
            sa_pe sa_pe_inst (
                .clk        (clk),
                .cnt_rst    (cnt_rst),
                .clear      (clear),
                .mode       (mode),
                .w_in       (w_bus[r][c]),
                .w_vld_in   (w_vbus[r][c]),
                .px_in      (px_bus[r][c]),
                .px_vld_in  (px_vbus[r][c]),
                .w_out      (w_bus[r][c+1]),
                .w_vld_out  (w_vbus[r][c+1]),
                .px_out     (px_bus[r+1][c]),
                .px_vld_out (px_vbus[r+1][c]),
                .acc        (acc_all[r][c])
            );
        end
    end

endmodule

/* sa_ctrl.sv */
`timescale 1ns/1ps

module sa_ctrl (
    input  logic                       clk,
    input  logic                       cnt_rst,
    input  logic                       start,
    input  logic                       mode_in,
    input  logic [sa_pkg::depth_w-1:0] depth_in,
    input  logic                       drain_done,
    output logic                       mode,
    output logic                       feed_en,
    output logic                       clear,
    output logic                       drain_go,
    output logic                       busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_feed,
        st_flush,
        st_drain
    } state_t;

    state_t                     state;
    logic [sa_pkg::depth_w-1:0] depth_q;
    logic [sa_pkg::depth_w-1:0] step_cnt;
    logic [sa_pkg::flush_w-1:0] flush_cnt;
    logic                       accept;
    logic                       flush_last;

    // a start outside idle is dropped
    assign accept     = (state == st_idle) && start;
    assign flush_last = flush_cnt == sa_pkg::flush_w'(sa_pkg::flush_cycles - 1);

    //////////////////////////////
    // tile sequencer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            state     <= st_idle;
            mode      <= 1'b0;
            step_cnt  <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_feed;
                        mode     <= mode_in;
                        step_cnt <= '0;
                    end
                end
                // depth host steps on back-to-back cycles
                st_feed: begin
                    if (step_cnt == depth_q - sa_pkg::depth_w'(1)) begin
                        state     <= st_flush;
                        flush_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + sa_pkg::depth_w'(1);
                    end
                end
                // let the last step ripple to the far corner
                st_flush: begin
                    if (flush_last) begin
                        state <= st_drain;
                    end else begin
                        flush_cnt <= flush_cnt + sa_pkg::flush_w'(1);
                    end
                end
                default: begin
                    if (drain_done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // tile length captured with the start
    always_ff @(posedge clk) begin
        if (accept) begin
            depth_q <= depth_in;
        end
    end

    assign feed_en  = state == st_feed;
    // zero the accumulators in the accept cycle ahead of the first step
    assign clear    = accept;
    assign drain_go = (state == st_flush) && flush_last;
    assign busy     = state != st_idle;

endmodule

/* sa_drain.sv */
`timescale 1ns/1ps

module sa_drain (
    input  logic                                                          clk,
    input  logic                                                          cnt_rst,
    input  logic                                                          drain_go,
    input  logic [sa_pkg::sa_rows-1:0][sa_pkg::sa_cols-1:0][sa_pkg::pe_w-1:0] acc_all,
    input  logic                                                          out_credit,
    output logic                                                          out_valid,
    output logic [sa_pkg::chan_idx_w-1:0]                                 out_chan,
    output logic [sa_pkg::chan_w-1:0]                                     out_data,
    output logic                                                          done,
    output logic                                                          drain_done
);

    logic [sa_pkg::cred_w-1:0]     credits;
    logic [sa_pkg::chan_idx_w-1:0] chan;
    logic                          drain_active;
    logic                          send;
    logic                          last_chan;
    logic                          last_beat;

    // drain_go itself may carry channel 0 if a credit is free
    assign send      = (drain_active || drain_go) && (credits != '0);
    assign last_chan = chan == sa_pkg::chan_idx_w'(sa_pkg::sa_cols - 1);

    //////////////////////////////
    // credits and channel walk
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            credits      <= sa_pkg::cred_w'(sa_pkg::out_credits);
            chan         <= '0;
            drain_active <= 1'b0;
            out_valid    <= 1'b0;
            last_beat    <= 1'b0;
        end else begin
            // returned slot and spent beat may land together
            credits   <= credits + sa_pkg::cred_w'(out_credit) - sa_pkg::cred_w'(send);
            out_valid <= send;
            last_beat <= send && last_chan;
            if (drain_go) begin
                drain_active <= 1'b1;
            end
            if (send) begin
                if (last_chan) begin
                    chan         <= '0;
                    drain_active <= 1'b0;
                end else begin
                    chan <= chan + sa_pkg::chan_idx_w'(1);
                end
            end
        end
    end

    // beat payload holds while out of credit
    always_ff @(posedge clk) begin
        if (send) begin
            out_chan <= chan;
            // row r of the channel at bit r*pe_w
            for (int r = 0; r < sa_pkg::sa_rows; r++) begin
                out_data[r*sa_pkg::pe_w +: sa_pkg::pe_w] <= acc_all[r][chan];
            end
        end
    end

    assign done       = last_beat;
    assign drain_done = last_beat;

endmodule

/* sa_top.sv */
`timescale 1ns/1ps

module sa_top (
    input  logic                                          clk,
    input  logic                                          cnt_rst,
    input  logic                                          start,
    input  logic                                          mode,
    input  logic [sa_pkg::depth_w-1:0]                    depth,
    input  logic [sa_pkg::sa_rows-1:0][sa_pkg::row_w-1:0] row_in,
    input  logic [sa_pkg::sa_cols-1:0][sa_pkg::col_w-1:0] col_in,
    input  logic                                          out_credit,
    output logic                                          busy,
    output logic                                          out_valid,
    output logic [sa_pkg::chan_idx_w-1:0]                 out_chan,
    output logic [sa_pkg::chan_w-1:0]                     out_data,
    output logic                                          done
);

    // controller outputs
    logic tile_mode;
    logic feed_en;
    logic clear;
    logic drain_go;
    logic drain_done;

    // skewed streams into the array
    logic [sa_pkg::sa_rows-1:0][sa_pkg::row_w-1:0] w_skew;
    logic [sa_pkg::sa_rows-1:0]                    w_vld;
    logic [sa_pkg::sa_cols-1:0][sa_pkg::col_w-1:0] px_skew;
    logic [sa_pkg::sa_cols-1:0]                    px_vld;

    logic [sa_pkg::sa_rows-1:0][sa_pkg::sa_cols-1:0][sa_pkg::pe_w-1:0] acc_all;

    sa_ctrl sa_ctrl_inst (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .start      (start),
        .mode_in    (mode),
        .depth_in   (depth),
        .drain_done (drain_done),
        .mode       (tile_mode),
        .feed_en    (feed_en),
        .clear      (clear),
        .drain_go   (drain_go),
        .busy       (busy)
    );

    //////////////////////////////
    // feeders
    //////////////////////////////
    sa_skew #(
        .payload_t (logic [sa_pkg::row_w-1:0]),
        .n         (sa_pkg::sa_rows)
    ) row_skew_inst (
        .clk     (clk),
        .cnt_rst (cnt_rst),
        .in      (row_in),
        .in_vld  (feed_en),
        .out     (w_skew),
        .out_vld (w_vld)
    );

    sa_skew #(
        .payload_t (logic [sa_pkg::col_w-1:0]),
        .n         (sa_pkg::sa_cols)
    ) col_skew_inst (
        .clk     (clk),
        .cnt_rst (cnt_rst),
        .in      (col_in),
        .in_vld  (feed_en),
        .out     (px_skew),
        .out_vld (px_vld)
    );

    sa_array sa_array_inst (
        .clk     (clk),
        .cnt_rst (cnt_rst),
        .clear   (clear),
        .mode    (tile_mode),
        .w_in    (w_skew),
        .w_vld   (w_vld),
        .px_in   (px_skew),
        .px_vld  (px_vld),
        .acc_all (acc_all)
    );

    // one channel per credited beat
    sa_drain sa_drain_inst (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .drain_go   (drain_go),
        .acc_all    (acc_all),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .done       (done),
        .drain_done (drain_done)
    );

endmodule

/* sa_checker.sv */
`timescale 1ns/1ps

module sa_checker (
    input logic                          clk,
    input logic                          cnt_rst,
    input logic                          busy,
    input logic                          out_valid,
    input logic [sa_pkg::chan_idx_w-1:0] out_chan,
    input logic [sa_pkg::chan_w-1:0]     out_data,
    input logic                          done,
    input logic                          out_credit
);

    // current test and its expected channel words
    string test_name = "";
    logic [sa_pkg::sa_cols-1:0][sa_pkg::chan_w-1:0] exp_beats;
    bit    active = 1'b0;
    // idle test allows no beat and no busy
    bit    idle_mode = 1'b0;
    int    beats = 0;
    int    test_errs = 0;
    string first_msg = "";
    // beats sent and not yet freed by the consumer
    int    outstanding = 0;
    // credit seen one edge ago counts toward the next send decision
    logic  cred_q = 1'b0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    stray_cnt = 0;

    // only the first problem of a test makes its line
    task automatic note(input string msg);
        if (!active) begin
            // between tests a problem gets a line of its own
            $display("%s", msg);
            fail_cnt++;
        end else begin
            if (test_errs == 0) begin
                first_msg = msg;
            end
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name, input bit idle,
                              input logic [sa_pkg::sa_cols-1:0][sa_pkg::chan_w-1:0] exp);
        test_name = name;
        idle_mode = idle;
        exp_beats = exp;
        beats     = 0;
        test_errs = 0;
        first_msg = "";
        active    = 1'b1;
    endtask

    task automatic note_timeout(input string what);
        note($sformatf("test %s failed, timed out waiting for %s", test_name, what));
    endtask

    task automatic end_test();
        if (!idle_mode && beats != sa_pkg::sa_cols) begin
            note($sformatf("test %s failed, %0d beats came out instead of %0d",
                           test_name, beats, sa_pkg::sa_cols));
        end
        if (test_errs == 0) begin
            $display("test %s passed", test_name);
            pass_cnt++;
        end else begin
            $display("%s", first_msg);
            fail_cnt++;
        end
        active = 1'b0;
    endtask

    task automatic print_totals();
        $display("totals %0d passed, %0d failed, %0d stray beats", pass_cnt, fail_cnt, stray_cnt);
    endtask

    //////////////////////////////
    // beat monitor
    //////////////////////////////
    always @(posedge clk) begin
        if (cnt_rst) begin
            outstanding = 0;
            cred_q      = 1'b0;
        end else begin
            if (active && idle_mode && (busy || out_valid || done)) begin
                note($sformatf("test %s failed, busy, out_valid or done rose with no start",
                               test_name));
            end
            if (done && !out_valid) begin
                note($sformatf("test %s failed, done pulsed without a beat", test_name));
            end
            if (out_valid) begin
                // consumer buffer already full when this beat was sent
                if (outstanding >= sa_pkg::out_credits) begin
                    note($sformatf("test %s failed, beat sent with no credit left", test_name));
                end
                outstanding++;
                if (!active) begin
                    stray_cnt++;
                end else if (beats >= sa_pkg::sa_cols) begin
                    note($sformatf("test %s failed, extra beat after the last channel",
                                   test_name));
                end else begin
                    // channels come out in order 0, 1, ...
                    if (out_chan !== sa_pkg::chan_idx_w'(beats)) begin
                        note($sformatf("error %s expected channel %0d actual channel %0d",
                                       test_name, beats, out_chan));
                    end else if (out_data !== exp_beats[beats]) begin
                        note($sformatf("error %s channel %0d expected %h actual %h",
                                       test_name, beats, exp_beats[beats], out_data));
                    end
                    if (done !== (beats == sa_pkg::sa_cols - 1)) begin
                        note($sformatf("test %s failed, done did not mark the last beat",
                                       test_name));
                    end
                    beats++;
                end
            end
            outstanding -= int'(cred_q);
            cred_q = out_credit;
        end
    end

endmodule

/* tb_sa.sv */
`timescale 1ns/1ps

module tb_sa;

    localparam int n_tests = 7;
    // cycles allowed for a whole tile including stalls
    localparam int tile_timeout = 300;
    localparam int idle_timeout = 100;

    logic                                          clk;
    logic                                          cnt_rst;
    logic                                          start;
    logic                                          mode;
    logic [sa_pkg::depth_w-1:0]                    depth;
    logic [sa_pkg::sa_rows-1:0][sa_pkg::row_w-1:0] row_in;
    logic [sa_pkg::sa_cols-1:0][sa_pkg::col_w-1:0] col_in;
    logic                                          out_credit = 1'b0;
    logic                                          busy;
    logic                                          out_valid;
    logic [sa_pkg::chan_idx_w-1:0]                 out_chan;
    logic [sa_pkg::chan_w-1:0]                     out_data;
    logic                                          done;

    // tile contents with one entry per step
    logic [sa_pkg::sa_rows-1:0][sa_pkg::row_w-1:0] row_mem [sa_pkg::max_depth];
    logic [sa_pkg::sa_cols-1:0][sa_pkg::col_w-1:0] col_mem [sa_pkg::max_depth];
    logic [31:0] rng;
    int          cyc = 0;
    int          cur_hold = 0;
    // cycle at which each held slot is handed back
    int          due_q [$];
    bit          timed_out;

    //////////////////////////////
    // stimulus table
    //////////////////////////////
    string t_name    [n_tests] = '{"m0_depth1", "m0_depth16", "m1_depth8", "m0_after_m1",
                                   "m0_hold", "m1_stalled", "busy_start"};
    bit    t_mode    [n_tests] = '{0, 0, 1, 0, 0, 1, 0};
    int    t_depth   [n_tests] = '{1, 16, 8, 3, 4, 6, 7};
    // cycles the consumer keeps a slot before returning its credit
    int    t_hold    [n_tests] = '{0, 0, 0, 0, 40, 0, 0};
    // second start pulsed while busy
    bit    t_restart [n_tests] = '{0, 0, 0, 0, 0, 0, 1};
    // quiet cycles after the last beat
    // a short gap leaves credits outstanding for the next tile
    int    t_gap     [n_tests] = '{8, 8, 8, 8, 2, 8, 30};

    sa_top sa_top_inst (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .start      (start),
        .mode       (mode),
        .depth      (depth),
        .row_in     (row_in),
        .col_in     (col_in),
        .out_credit (out_credit),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .done       (done)
    );

    sa_checker sa_checker_inst (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .done       (done),
        .out_credit (out_credit)
    );

    always #50 clk = ~clk;

    // consumer frees each slot cur_hold cycles after its beat
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cnt_rst) begin
            due_q.delete();
            out_credit <= 1'b0;
        end else begin
            if (out_valid) begin
                due_q.push_back(cyc + cur_hold);
            end
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                out_credit <= 1'b1;
                void'(due_q.pop_front());
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    //////////////////////////////
    // golden model
    //////////////////////////////
    // lanes per element from the signed byte and nibble products
    function automatic logic [sa_pkg::sa_cols-1:0][sa_pkg::chan_w-1:0] expected_beats(
        input bit m, input int n);
        int acc [sa_pkg::lanes];
        int wv;
        int nib [2];
        int pb [2];
        logic [sa_pkg::sa_cols-1:0][sa_pkg::chan_w-1:0] res;
        res = '0;
        for (int c = 0; c < sa_pkg::sa_cols; c++) begin
            for (int r = 0; r < sa_pkg::sa_rows; r++) begin
                for (int l = 0; l < sa_pkg::lanes; l++) begin
                    acc[l] = 0;
                end
                for (int s = 0; s < n; s++) begin
                    wv     = int'($signed(row_mem[s][r]));
                    nib[0] = int'($signed(row_mem[s][r][3:0]));
                    nib[1] = int'($signed(row_mem[s][r][7:4]));
                    pb[0]  = int'($signed(col_mem[s][c][7:0]));
                    pb[1]  = int'($signed(col_mem[s][c][15:8]));
                    for (int p = 0; p < 2; p++) begin
                        if (!m) begin
                            acc[p] += wv * pb[p];
                        end else begin
                            for (int w = 0; w < 2; w++) begin
                                acc[2*w+p] += nib[w] * pb[p];
                            end
                        end
                    end
                end
                // row r lane l of the channel word wrapped to acc_w
                for (int l = 0; l < sa_pkg::lanes; l++) begin
                    res[c][(r*sa_pkg::lanes + l)*sa_pkg::acc_w +: sa_pkg::acc_w] =
                        sa_pkg::acc_w'(acc[l]);
                end
            end
        end
        return res;
    endfunction

    task automatic wait_idle(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < idle_timeout && !ok; i++) begin
            @(negedge clk);
            ok = !busy;
        end
    endtask

    task automatic wait_beats(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < tile_timeout && !ok; i++) begin
            @(negedge clk);
            ok = sa_checker_inst.beats >= sa_pkg::sa_cols;
        end
    endtask

    //////////////////////////////
    // one table row
    //////////////////////////////
    task automatic run_tile(input int t);
        logic [sa_pkg::sa_cols-1:0][sa_pkg::chan_w-1:0] exp;
        logic [31:0] rnd;
        bit ok;
        for (int s = 0; s < t_depth[t]; s++) begin
            for (int r = 0; r < sa_pkg::sa_rows; r++) begin
                rnd = next_rand();
                row_mem[s][r] = rnd[7:0];
            end
            for (int c = 0; c < sa_pkg::sa_cols; c++) begin
                rnd = next_rand();
                col_mem[s][c] = rnd[15:0];
            end
        end
        // both nibbles negative at least once per 4x8 tile
        if (t_mode[t]) begin
            row_mem[0][0] = 8'h9e;
        end
        exp = expected_beats(t_mode[t], t_depth[t]);
        @(negedge clk);
        cur_hold = t_hold[t];
        sa_checker_inst.begin_test(t_name[t], 1'b0, exp);
        wait_idle(ok);
        if (!ok) begin
            sa_checker_inst.note_timeout("busy to fall");
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            start <= 1'b1;
            mode  <= t_mode[t];
            depth <= sa_pkg::depth_w'(t_depth[t]);
            for (int s = 0; s < t_depth[t]; s++) begin
                @(posedge clk);
                // steps follow the start on back-to-back cycles
                start  <= (s == 0) && t_restart[t];
                row_in <= row_mem[s];
                col_in <= col_mem[s];
                if (s == 0 && t_restart[t]) begin
                    mode  <= !t_mode[t];
                    depth <= sa_pkg::depth_w'(1);
                end
            end
            @(posedge clk);
            start  <= 1'b0;
            row_in <= '0;
            col_in <= '0;
            wait_beats(ok);
            if (!ok) begin
                sa_checker_inst.note_timeout("the channel beats");
                timed_out = 1'b1;
            end else begin
                repeat (t_gap[t]) @(posedge clk);
            end
        end
        @(negedge clk);
        sa_checker_inst.end_test();
    endtask

    initial begin
        clk       = 1'b0;
        cnt_rst   = 1'b1;
        start     = 1'b0;
        mode      = 1'b0;
        depth     = '0;
        row_in    = '0;
        col_in    = '0;
        rng       = 32'd29537;
        timed_out = 1'b0;
        repeat (16) @(posedge clk);
        cnt_rst <= 1'b0;
        // quiet window with no start at all
        @(negedge clk);
        sa_checker_inst.begin_test("reset_idle", 1'b1, '0);
        repeat (12) @(posedge clk);
        @(negedge clk);
        sa_checker_inst.end_test();
        for (int t = 0; t < n_tests && !timed_out; t++) begin
            run_tile(t);
        end
        sa_checker_inst.print_totals();
        if (!timed_out && sa_checker_inst.fail_cnt == 0 && sa_checker_inst.stray_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
sa_pkg.sv
sa_skew.sv
sa_pe.sv
sa_array.sv
sa_ctrl.sv
sa_drain.sv
sa_top.sv
sa_checker.sv
tb_sa.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_sa
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS     = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
